/* lcd_init_table.svh */
// ILI9341 power-up command sequence followed by the full-screen window setup
// entries are {dc, byte}: a command byte then its parameter bytes
localparam lcd_pkg::lcd_word_t LCD_TABLE [lcd_pkg::INIT_WORDS + lcd_pkg::WINDOW_WORDS] = '{
    // sleep out, needs a long settle before the next word
    {1'b0, 8'h11},
    // power control B
    {1'b0, 8'hCF}, {1'b1, 8'h00}, {1'b1, 8'hC1}, {1'b1, 8'h30},
    // power-on sequence control
    {1'b0, 8'hED}, {1'b1, 8'h64}, {1'b1, 8'h03}, {1'b1, 8'h12}, {1'b1, 8'h81},
    // driver timing control A
    {1'b0, 8'hE8}, {1'b1, 8'h85}, {1'b1, 8'h10}, {1'b1, 8'h78},
    // power control A
    {1'b0, 8'hCB}, {1'b1, 8'h39}, {1'b1, 8'h2C}, {1'b1, 8'h00}, {1'b1, 8'h34},
    {1'b1, 8'h02},
    // pump ratio, driver timing B
    {1'b0, 8'hF7}, {1'b1, 8'h20},
    {1'b0, 8'hEA}, {1'b1, 8'h00}, {1'b1, 8'h00},
    // power control 1 and 2, VCOM
    {1'b0, 8'hC0}, {1'b1, 8'h21},
    {1'b0, 8'hC1}, {1'b1, 8'h11},
    {1'b0, 8'hC5}, {1'b1, 8'h2D}, {1'b1, 8'h33},
    // memory access: portrait, top left to bottom right
    {1'b0, 8'h36}, {1'b1, 8'h40},
    // 16 bit pixel format
    {1'b0, 8'h3A}, {1'b1, 8'h55},
    // frame rate, display function, interface control
    {1'b0, 8'hB1}, {1'b1, 8'h00}, {1'b1, 8'h17},
    {1'b0, 8'hB6}, {1'b1, 8'h0A}, {1'b1, 8'hA2},
    {1'b0, 8'hF6}, {1'b1, 8'h01}, {1'b1, 8'h30},
    // 3G off, gamma curve 1
    {1'b0, 8'hF2}, {1'b1, 8'h00},
    {1'b0, 8'h26}, {1'b1, 8'h01},
    // positive gamma
    {1'b0, 8'hE0}, {1'b1, 8'hD0}, {1'b1, 8'h00}, {1'b1, 8'h02}, {1'b1, 8'h07},
    {1'b1, 8'h0B}, {1'b1, 8'h1A}, {1'b1, 8'h31}, {1'b1, 8'h54}, {1'b1, 8'h40},
    {1'b1, 8'h29}, {1'b1, 8'h12}, {1'b1, 8'h12}, {1'b1, 8'h12}, {1'b1, 8'h17},
    // negative gamma
    {1'b0, 8'hE1}, {1'b1, 8'hD0}, {1'b1, 8'h00}, {1'b1, 8'h02}, {1'b1, 8'h07},
    {1'b1, 8'h05}, {1'b1, 8'h25}, {1'b1, 8'h2D}, {1'b1, 8'h44}, {1'b1, 8'h45},
    {1'b1, 8'h1C}, {1'b1, 8'h18}, {1'b1, 8'h16}, {1'b1, 8'h1C}, {1'b1, 8'h1D},
    // window: columns 0..239, pages 0..239
    {1'b0, 8'h2A}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, 8'hEF},
    {1'b0, 8'h2B}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, 8'hEF},
    // display on, then memory write opens the pixel stream
    {1'b0, 8'h29},
    {1'b0, 8'h2C}
};

/* lcd_pkg.sv */
// shared definitions for the serial LCD controller
// word format, FSM encodings, panel geometry and pixel colour bytes
package lcd_pkg;

    // one panel word, dc = 1 for data and 0 for a command
    typedef struct packed {
        logic       dc;
        logic [7:0] data;
    } lcd_word_t;

    typedef enum logic [2:0] {
        RST_LOW,
        RST_WAIT,
        RST_HIGH,
        HIGH_WAIT,
        INIT,
        SLEEP_WAIT,
        WINDOW,
        SCAN
    } seq_phase_e;

    typedef enum logic [1:0] {
        IDLE,
        START,
        SHIFT,
        STOP
    } wr_state_e;

    // command table sections
    localparam logic [6:0] INIT_WORDS   = 7'd79;
    localparam logic [6:0] WINDOW_WORDS = 7'd12;

    // 240 x 240 panel, two bytes per pixel
    localparam int         LINE_PIXELS = 240;
    localparam logic [8:0] LINE_BYTES  = 9'd480;
    localparam logic [7:0] FRAME_LINES = 8'd240;

    // colour of a lit pixel, high byte first
    localparam logic [7:0] PIX_ON_HI = 8'hF4;
    localparam logic [7:0] PIX_ON_LO = 8'h10;

    localparam logic [1:0] WR_CREDITS  = 2'd2;
    localparam logic [1:0] RENDER_WAIT = 2'd2;

endpackage

/* lcd_word_if.sv */
`timescale 1ns/1ps
// word channel from the sequencer to the serial writer
// credit based: one credit comes back per word taken off the writer buffer
interface lcd_word_if;

    logic               valid;
    lcd_pkg::lcd_word_t word;
    logic               credit;

    modport src (
        output valid,
        output word,
        input  credit
    );

    modport sink (
        input  valid,
        input  word,
        output credit
    );

endinterface

/* lcd_cmd_rom.sv */
`timescale 1ns/1ps
// command ROM
// combinational lookup of init and window words
module lcd_cmd_rom (
    input  logic [6:0]         idx,
    input  logic               window,
    output lcd_pkg::lcd_word_t word
);

`include "lcd_init_table.svh"

    logic [6:0] addr;

    // window words sit right after the init section
    assign addr = window ? idx + lcd_pkg::INIT_WORDS : idx;

    always_comb begin
        if (addr < lcd_pkg::INIT_WORDS + lcd_pkg::WINDOW_WORDS) begin
            word = LCD_TABLE[addr];
        end else begin
            word = '0;
        end
    end

endmodule

/* lcd_pixel_scan.sv */
`timescale 1ns/1ps
// pixel scan
// requests a monochrome line, latches it and offers the sequencer
// two bytes per pixel starting at bit 0
module lcd_pixel_scan (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            scan_en,
    input  logic [lcd_pkg::LINE_PIXELS-1:0] data_in,
    input  logic                            pix_take,
    output logic                            pix_valid,
    output logic [7:0]                      pix_byte,
    output logic                            render_en
);

    typedef enum logic [1:0] {
        SC_REQ,
        SC_WAIT,
        SC_STREAM
    } scan_state_e;

    scan_state_e                     state;
    logic [1:0]                      wait_cnt;
    logic                            wait_done;
    logic [lcd_pkg::LINE_PIXELS-1:0] line_q;
    logic [8:0]                      byte_cnt;
    logic                            pix_bit;

    assign wait_done = wait_cnt == lcd_pkg::RENDER_WAIT - 2'd1;
    assign pix_valid = state == SC_STREAM;

    // byte k belongs to pixel k/2 and its low bit picks the half
    assign pix_bit = line_q[byte_cnt[8:1]];

    always_comb begin
        if (!pix_bit) begin
            pix_byte = 8'h00;
        end else if (byte_cnt[0]) begin
            pix_byte = lcd_pkg::PIX_ON_LO;
        end else begin
            pix_byte = lcd_pkg::PIX_ON_HI;
        end
    end

    // source gets RENDER_WAIT cycles to present the line
    always_ff @(posedge clk) begin
        if (state == SC_WAIT && wait_done) begin
            line_q <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= SC_REQ;
            render_en <= 1'b0;
            wait_cnt  <= 2'd0;
            byte_cnt  <= 9'd0;
        end else begin
            render_en <= 1'b0;
            case (state)
                SC_REQ: begin
                    if (scan_en) begin
                        render_en <= 1'b1;
                        wait_cnt  <= 2'd0;
                        state     <= SC_WAIT;
                    end
                end
                SC_WAIT: begin
                    if (wait_done) begin
                        byte_cnt <= 9'd0;
                        state    <= SC_STREAM;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                SC_STREAM: begin
                    if (pix_take) begin
                        if (byte_cnt == lcd_pkg::LINE_BYTES - 9'd1) begin
                            state <= SC_REQ;
                        end else begin
                            byte_cnt <= byte_cnt + 9'd1;
                        end
                    end
                end
                default: state <= SC_REQ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    // the sequencer only takes what is on offer
    a_take_valid: assert property (@(posedge clk) disable iff (!rstn)
        pix_take |-> pix_valid);

endmodule

/* lcd_sequencer.sv */
`timescale 1ns/1ps
// panel sequencer
// reset pulse and settle delays, init table, sleep-out wait, window setup,
// then an endless pixel stream; sends words to the writer against credits
module lcd_sequencer #(
    parameter int DELAY_LONG = 1000
) (
    input  logic       clk,
    input  logic       rstn,
    lcd_word_if.src    wr,
    output logic       lcd_rst,
    output logic       scan_en,
    input  logic       pix_valid,
    input  logic [7:0] pix_byte,
    output logic       pix_take
);

    // one word on the wire, CS fall to CS rise
    localparam int FRAME_CYCLES = 18;
    localparam int DW           = $clog2(DELAY_LONG + FRAME_CYCLES + 1);

    lcd_pkg::seq_phase_e phase;
    logic [DW-1:0]       dly;
    logic                dly_done;
    logic                sleep_done;
    logic [6:0]          idx;
    logic [1:0]          credits;
    logic                has_credit;
    logic                send;
    lcd_pkg::lcd_word_t  rom_word;

    lcd_cmd_rom rom_inst (
        .idx    (idx),
        .window (phase == lcd_pkg::WINDOW),
        .word   (rom_word)
    );

    assign has_credit = credits != 2'd0;
    assign scan_en    = phase == lcd_pkg::SCAN;
    assign pix_take   = scan_en && pix_valid && has_credit;
    assign send       = pix_take ||
                        (has_credit && (phase == lcd_pkg::INIT || phase == lcd_pkg::WINDOW));

    assign wr.valid = send;
    assign wr.word  = scan_en ? lcd_pkg::lcd_word_t'({1'b1, pix_byte}) : rom_word;

    assign dly_done   = dly == DW'(DELAY_LONG - 1);
    // sleep-out word is still shifting out when its credit returns
    assign sleep_done = dly == DW'(DELAY_LONG + FRAME_CYCLES - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= lcd_pkg::WR_CREDITS;
        end else begin
            credits <= credits + {1'b0, wr.credit} - {1'b0, send};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase machine

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase   <= lcd_pkg::RST_LOW;
            lcd_rst <= 1'b1;
            dly     <= '0;
            idx     <= 7'd0;
        end else begin
            case (phase)
                lcd_pkg::RST_LOW: begin
                    lcd_rst <= 1'b0;
                    dly     <= '0;
                    phase   <= lcd_pkg::RST_WAIT;
                end
                lcd_pkg::RST_WAIT: begin
                    if (dly_done) begin
                        phase <= lcd_pkg::RST_HIGH;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                lcd_pkg::RST_HIGH: begin
                    lcd_rst <= 1'b1;
                    dly     <= '0;
                    phase   <= lcd_pkg::HIGH_WAIT;
                end
                lcd_pkg::HIGH_WAIT: begin
                    if (dly_done) begin
                        phase <= lcd_pkg::INIT;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                lcd_pkg::INIT: begin
                    if (send) begin
                        idx <= idx + 7'd1;
                        if (idx == 7'd0) begin
                            // sleep out just went
                            dly   <= '0;
                            phase <= lcd_pkg::SLEEP_WAIT;
                        end else if (idx == lcd_pkg::INIT_WORDS - 7'd1) begin
                            idx   <= 7'd0;
                            phase <= lcd_pkg::WINDOW;
                        end
                    end
                end
                lcd_pkg::SLEEP_WAIT: begin
                    // count only once the writer has drained
                    if (credits == lcd_pkg::WR_CREDITS) begin
                        if (sleep_done) begin
                            phase <= lcd_pkg::INIT;
                        end else begin
                            dly <= dly + 1'b1;
                        end
                    end
                end
                lcd_pkg::WINDOW: begin
                    if (send) begin
                        if (idx == lcd_pkg::WINDOW_WORDS - 7'd1) begin
                            phase <= lcd_pkg::SCAN;
                        end else begin
                            idx <= idx + 7'd1;
                        end
                    end
                end
                // scan runs until the next reset
                default: ;
            endcase
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rstn)
        credits <= lcd_pkg::WR_CREDITS);

endmodule

/* lcd_spi_writer.sv */
`timescale 1ns/1ps
// serial writer
// two-word buffer feeding an 18-cycle CS/SCK/SDA frame, WR carries dc;
// a credit goes back to the sequencer for every word popped
module lcd_spi_writer (
    input  logic     clk,
    input  logic     rstn,
    lcd_word_if.sink wr,
    output logic     lcd_cs,
    output logic     lcd_sck,
    output logic     lcd_sda,
    output logic     lcd_wr
);

    lcd_pkg::lcd_word_t fifo_q [2];
    logic               wp;
    logic               rp;
    logic [1:0]         count;
    logic               pop;
    lcd_pkg::wr_state_e state;
    logic [7:0]         shreg;
    logic [3:0]         bit_cnt;

    assign pop       = (state == lcd_pkg::IDLE) && (count != 2'd0);
    assign wr.credit = pop;

    ////////////////////////////////////////////////////////////////////////////
    // word buffer

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            fifo_q[wp] <= wr.word;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wp    <= 1'b0;
            rp    <= 1'b0;
            count <= 2'd0;
        end else begin
            if (wr.valid) begin
                wp <= ~wp;
            end
            if (pop) begin
                rp <= ~rp;
            end
            count <= count + {1'b0, wr.valid} - {1'b0, pop};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // serializer

    // shift on every falling SCK so bit 6 is always next
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= fifo_q[rp].data;
        end else if (state == lcd_pkg::SHIFT && bit_cnt[0]) begin
            shreg <= shreg << 1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= lcd_pkg::IDLE;
            bit_cnt <= 4'd0;
            lcd_cs  <= 1'b1;
            lcd_sck <= 1'b0;
            lcd_sda <= 1'b0;
            lcd_wr  <= 1'b0;
        end else begin
            case (state)
                lcd_pkg::IDLE: begin
                    if (pop) begin
                        lcd_cs <= 1'b0;
                        lcd_wr <= fifo_q[rp].dc;
                        state  <= lcd_pkg::START;
                    end
                end
                lcd_pkg::START: begin
                    lcd_sda <= shreg[7];
                    bit_cnt <= 4'd0;
                    state   <= lcd_pkg::SHIFT;
                end
                lcd_pkg::SHIFT: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (!bit_cnt[0]) begin
                        lcd_sck <= 1'b1;
                    end else begin
                        lcd_sck <= 1'b0;
                        if (bit_cnt == 4'd15) begin
                            // last bit done, close the frame
                            lcd_cs <= 1'b1;
                            state  <= lcd_pkg::STOP;
                        end else begin
                            lcd_sda <= shreg[6];
                        end
                    end
                end
                default: state <= lcd_pkg::IDLE;
            endcase
        end
    end

    a_sck_in_frame: assert property (@(posedge clk) disable iff (!rstn)
        lcd_sck |-> !lcd_cs);

    // sequencer credit count must keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        wr.valid |-> count < lcd_pkg::WR_CREDITS);

endmodule

/* lcd_ctrl_top.sv */
`timescale 1ns/1ps
// serial LCD controller top
// panel bring-up and monochrome frame streaming for a 240x240 ILI9341 panel
module lcd_ctrl_top #(
    parameter int DELAY_LONG = 1000
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [lcd_pkg::LINE_PIXELS-1:0] data_in,
    output logic                            lcd_cs,
    output logic                            lcd_sck,
    output logic                            lcd_sda,
    output logic                            lcd_wr,
    output logic                            lcd_rst,
    output logic                            render_en
);

    logic       scan_en;
    logic       pix_valid;
    logic       pix_take;
    logic [7:0] pix_byte;

    lcd_word_if word_if ();

    lcd_sequencer #(
        .DELAY_LONG (DELAY_LONG)
    ) seq_inst (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (word_if.src),
        .lcd_rst   (lcd_rst),
        .scan_en   (scan_en),
        .pix_valid (pix_valid),
        .pix_byte  (pix_byte),
        .pix_take  (pix_take)
    );

    lcd_pixel_scan scan_inst (
        .clk       (clk),
        .rstn      (rstn),
        .scan_en   (scan_en),
        .data_in   (data_in),
        .pix_take  (pix_take),
        .pix_valid (pix_valid),
        .pix_byte  (pix_byte),
        .render_en (render_en)
    );

    lcd_spi_writer writer_inst (
        .clk     (clk),
        .rstn    (rstn),
        .wr      (word_if.sink),
        .lcd_cs  (lcd_cs),
        .lcd_sck (lcd_sck),
        .lcd_sda (lcd_sda),
        .lcd_wr  (lcd_wr)
    );

endmodule

/* tb_lcd_ctrl.sv */
`timescale 1ns/1ps
// testbench for the serial LCD controller
// decodes the CS/SCK/SDA/WR bus back into words and checks panel reset,
// init and window tables, random pixel lines and serial framing
module tb_lcd_ctrl;

`include "lcd_init_table.svh"

    localparam int DELAY_LONG   = 40;
    localparam int WORD_TIMEOUT = 400;
    localparam int NUM_LINES    = 3;

    logic                            clk;
    logic                            rstn;
    logic [lcd_pkg::LINE_PIXELS-1:0] data_in;
    logic                            lcd_cs;
    logic                            lcd_sck;
    logic                            lcd_sda;
    logic                            lcd_wr;
    logic                            lcd_rst;
    logic                            render_en;

    int         seed;
    int         err_cnt;
    int         tests_run;
    int         tests_failed;
    int         render_cnt;
    int         words_seen;
    int         frame_err;
    int         gap_first;
    logic [8:0] rx_q [$];
    logic [8:0] exp_q [$];

    lcd_ctrl_top #(
        .DELAY_LONG (DELAY_LONG)
    ) lcd_ctrl_top_inst (
        .clk       (clk),
        .rstn      (rstn),
        .data_in   (data_in),
        .lcd_cs    (lcd_cs),
        .lcd_sck   (lcd_sck),
        .lcd_sda   (lcd_sda),
        .lcd_wr    (lcd_wr),
        .lcd_rst   (lcd_rst),
        .render_en (render_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic end_run();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        err_cnt++;
        $display("timeout: %s", why);
        end_run();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
        end
    endtask

    task automatic get_word(output logic [8:0] w);
        int n;
        n = 0;
        while (rx_q.size() == 0 && n < WORD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rx_q.size() == 0) begin
            abort_run("no word on the serial bus");
        end else begin
            w = rx_q.pop_front();
        end
    endtask

    task automatic check_reset_outputs();
        if (lcd_cs !== 1'b1) begin
            err_cnt++;
            $display("Fail lcd_cs: expected 0x1, got 0x%h", lcd_cs);
        end
        if (lcd_sck !== 1'b0) begin
            err_cnt++;
            $display("Fail lcd_sck: expected 0x0, got 0x%h", lcd_sck);
        end
        if (render_en !== 1'b0) begin
            err_cnt++;
            $display("Fail render_en: expected 0x0, got 0x%h", render_en);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // line source and reference model

    initial begin : line_source
        logic [255:0] raw;
        int           j;
        forever begin
            @(posedge clk);
            #1;
            if (render_en) begin
                for (j = 0; j < 8; j++) begin
                    raw[j*32 +: 32] = $random(seed);
                end
                data_in = raw[lcd_pkg::LINE_PIXELS-1:0];
                render_cnt++;
                // two bytes per pixel, bit 0 first
                for (j = 0; j < lcd_pkg::LINE_PIXELS; j++) begin
                    if (data_in[j]) begin
                        exp_q.push_back({1'b1, 8'hF4});
                        exp_q.push_back({1'b1, 8'h10});
                    end else begin
                        exp_q.push_back({1'b1, 8'h00});
                        exp_q.push_back({1'b1, 8'h00});
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus monitor

    initial begin : bus_monitor
        logic       prev_cs;
        logic       prev_sck;
        logic [7:0] shift;
        int         nrise;
        int         nlow;
        int         cyc;
        int         last_rise;
        prev_cs   = 1'b1;
        prev_sck  = 1'b0;
        shift     = 8'h00;
        nrise     = 0;
        nlow      = 0;
        cyc       = 0;
        last_rise = 0;
        forever begin
            @(negedge clk);
            cyc++;
            if (rstn) begin
                if (prev_cs && !lcd_cs) begin
                    nrise = 0;
                    nlow  = 0;
                    shift = 8'h00;
                    if (words_seen == 1) begin
                        gap_first = cyc - last_rise;
                    end
                end
                if (!lcd_cs) begin
                    nlow++;
                end
                if (lcd_sck && !prev_sck) begin
                    if (lcd_cs) begin
                        err_cnt++;
                        frame_err++;
                        $display("SCK rose while CS was high, cycle %0d", cyc);
                    end else begin
                        shift = {shift[6:0], lcd_sda};
                        nrise++;
                    end
                end
                // word ends on CS rise, dc is still on WR
                if (!prev_cs && lcd_cs) begin
                    if (nrise != 8) begin
                        err_cnt++;
                        frame_err++;
                        $display("Fail sck_rises: expected 0x8, got 0x%h", nrise);
                    end
                    if (nlow != 17) begin
                        err_cnt++;
                        frame_err++;
                        $display("Fail cs_low_cycles: expected 0x11, got 0x%h", nlow);
                    end
                    rx_q.push_back({lcd_wr, shift});
                    words_seen++;
                    last_rise = cyc;
                end
            end
            prev_cs  = lcd_cs;
            prev_sck = lcd_sck;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin : main_seq
        logic [8:0] w;
        int         n;
        int         k;
        int         line;
        int         errs0;
        seed         = 56449;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        render_cnt   = 0;
        words_seen   = 0;
        frame_err    = 0;
        gap_first    = 0;
        rstn         = 1'b0;
        data_in      = '0;

        errs0 = err_cnt;
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_reset_outputs();
        report_test("reset values", errs0);

        // panel reset pulse, then the settle time before the first word
        errs0 = err_cnt;
        n     = 0;
        while (lcd_rst && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (lcd_rst) begin
            abort_run("lcd_rst never went low");
        end
        n = 0;
        while (!lcd_rst && n < 8 * DELAY_LONG) begin
            n++;
            @(negedge clk);
        end
        if (!lcd_rst) begin
            abort_run("lcd_rst stuck low");
        end
        if (n < DELAY_LONG) begin
            err_cnt++;
            $display("Fail lcd_rst_low_cycles: expected >= 0x%h, got 0x%h", DELAY_LONG, n);
        end
        n = 0;
        while (lcd_cs && n < 8 * DELAY_LONG) begin
            n++;
            @(negedge clk);
        end
        if (lcd_cs) begin
            abort_run("first word never started after panel reset");
        end
        if (n < DELAY_LONG) begin
            err_cnt++;
            $display("Fail cs_high_after_rst: expected >= 0x%h, got 0x%h", DELAY_LONG, n);
        end
        report_test("panel reset pulse", errs0);

        errs0 = err_cnt;
        for (k = 0; k < lcd_pkg::INIT_WORDS; k++) begin
            get_word(w);
            if (w !== LCD_TABLE[k]) begin
                err_cnt++;
                $display("Fail init_word[%0d]: expected 0x%h, got 0x%h", k, LCD_TABLE[k], w);
            end
        end
        if (gap_first < DELAY_LONG) begin
            err_cnt++;
            $display("Fail sleep_gap: expected >= 0x%h, got 0x%h", DELAY_LONG, gap_first);
        end
        report_test("init stream", errs0);

        errs0 = err_cnt;
        for (k = 0; k < lcd_pkg::WINDOW_WORDS; k++) begin
            get_word(w);
            if (w !== LCD_TABLE[lcd_pkg::INIT_WORDS + k]) begin
                err_cnt++;
                $display("Fail window_word[%0d]: expected 0x%h, got 0x%h", k,
                         LCD_TABLE[lcd_pkg::INIT_WORDS + k], w);
            end
        end
        report_test("window stream", errs0);

        errs0 = err_cnt;
        for (line = 0; line < NUM_LINES; line++) begin
            for (k = 0; k < 480; k++) begin
                get_word(w);
                // next request only comes after the whole line is taken
                if (k == 0 && render_cnt != line + 1) begin
                    err_cnt++;
                    $display("Fail render_count: expected 0x%h, got 0x%h", line + 1,
                             render_cnt);
                end
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("pixel word arrived with no line requested, line %0d", line);
                end else if (w !== exp_q[0]) begin
                    err_cnt++;
                    $display("Fail pixel_word[%0d][%0d]: expected 0x%h, got 0x%h", line, k,
                             exp_q[0], w);
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
            end
        end
        report_test("pixel data", errs0);

        errs0 = err_cnt - frame_err;
        report_test("serial framing", errs0);
        end_run();
    end

endmodule

/* filelist.f */
+incdir+.
lcd_pkg.sv
lcd_word_if.sv
lcd_cmd_rom.sv
lcd_pixel_scan.sv
lcd_sequencer.sv
lcd_spi_writer.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv
